// ==== common/afi_wresp_consts.svh ====
`ifndef AFI_WRESP_CONSTS_SVH
`define AFI_WRESP_CONSTS_SVH

// compressor channels sharing one AXI HP port
`define AFI_CHANNELS  4

// chunk pointers and buffer lengths in 32-byte chunks
`define AFI_PTR_W     27

// write response id laid out as {unused, burst-1[1:0], eof, chn[1:0]}
`define AFI_ID_W      6

// pointer memory with a current and an eof entry for every channel
`define AFI_PTR_DEPTH 8

`endif

// ==== common/afi_wresp_pkg.sv ====
`default_nettype none

`include "afi_wresp_consts.svh"

package afi_wresp_pkg;

    typedef logic [`AFI_PTR_W-1:0]               chunk_ptr_t; // pointer or length, in chunks
    typedef logic [$clog2(`AFI_CHANNELS)-1:0]    chn_t;       // compressor channel number
    typedef logic [$clog2(`AFI_PTR_DEPTH)-1:0]   ptr_addr_t;  // {eof, chn} into pointer memory
    typedef logic [2:0]                          chunk_inc_t; // chunks per burst, 1..4
    typedef logic [`AFI_CHANNELS-1:0]            chn_mask_t;  // one bit per channel
    typedef logic [`AFI_ID_W-1:0]                resp_id_t;   // AXI bid as sent by the mux

    // one write-back sequence, shared by the response update and the clear
    typedef enum logic [2:0] {
        UPD_IDLE,   // waiting for a response or a clear request
        UPD_READ,   // read current pointer, add burst size
        UPD_WRAP,   // subtract buffer length
        UPD_WR_CUR, // write current pointer
        UPD_WR_EOF  // write frame pointer, eof bursts only
    } upd_state_t;

endpackage

`default_nettype wire

// ==== wresp/wresp_id_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

// accepts AXI write responses one at a time and runs the pointer update sequence
module wresp_id_decode (
    input  wire                            hclk,
    input  wire                            start_resetting_w,
    input  wire                            en,             // low - accept and drop every response
    input  wire                            afi_bvalid,
    input  wire afi_wresp_pkg::resp_id_t   afi_bid,        // {-, burst-1, eof, chn}
    input  wire                            clear_busy,     // pointer clear running or starting
    output wire                            afi_bready,
    output afi_wresp_pkg::chn_mask_t       eof_written,    // frame end confirmed, one pulse
    output wire                            resp_pending,   // keeps the clear arbiter off
    output afi_wresp_pkg::upd_state_t      upd_state,
    output afi_wresp_pkg::chn_t            upd_chn,
    output logic                           upd_eof_burst,
    output afi_wresp_pkg::chunk_inc_t      upd_inc
);

    afi_wresp_pkg::upd_state_t state_nx;   // next update state
    logic                      bready_r;   // ready while idle and no clear
    logic                      accept;     // response handshake this cycle
    logic                      take;       // handshake that starts an update

    assign afi_bready   = !en || bready_r;            // disabled block swallows responses
    assign accept       = afi_bvalid && afi_bready;
    assign take         = accept && en && (upd_state == afi_wresp_pkg::UPD_IDLE);
    assign resp_pending = afi_bvalid || (upd_state != afi_wresp_pkg::UPD_IDLE);

    always_comb begin
        state_nx = upd_state;
        case (upd_state)
            afi_wresp_pkg::UPD_IDLE: begin
                if (take) begin
                    state_nx = afi_wresp_pkg::UPD_READ;
                end
            end
            afi_wresp_pkg::UPD_READ: begin
                state_nx = afi_wresp_pkg::UPD_WRAP;
            end
            afi_wresp_pkg::UPD_WRAP: begin
                state_nx = afi_wresp_pkg::UPD_WR_CUR;
            end
            afi_wresp_pkg::UPD_WR_CUR: begin
                // frame pointer copy only at the end of a frame
                state_nx = upd_eof_burst ? afi_wresp_pkg::UPD_WR_EOF : afi_wresp_pkg::UPD_IDLE;
            end
            default: begin
                state_nx = afi_wresp_pkg::UPD_IDLE;      // UPD_WR_EOF ends the sequence
            end
        endcase
        if (!en) begin
            state_nx = afi_wresp_pkg::UPD_IDLE;          // held idle while disabled
        end
    end

    always_ff @(posedge hclk) begin
        if (start_resetting_w) begin
            upd_state   <= afi_wresp_pkg::UPD_IDLE;
            bready_r    <= 1'b0;
            eof_written <= '0;
        end else begin
            upd_state <= state_nx;
            bready_r  <= en && (state_nx == afi_wresp_pkg::UPD_IDLE) && !clear_busy; // drops on accept
            if (en && upd_eof_burst && (upd_state == afi_wresp_pkg::UPD_READ)) begin
                eof_written <= afi_wresp_pkg::chn_mask_t'(1) << upd_chn; // edge after accept
            end else begin
                eof_written <= '0;
            end
        end
    end

    // id fields, held for the whole update
    always_ff @(posedge hclk) begin
        if (take) begin
            upd_chn       <= afi_bid[1:0];
            upd_eof_burst <= afi_bid[2];
            upd_inc       <= {1'b0, afi_bid[4:3]} + 3'd1; // burst field is chunks minus one
        end
    end

endmodule

`default_nettype wire

// ==== wresp/wresp_clear_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afi_wresp_consts.svh"

// queues pointer clear requests and zeroes one channel's pointer pair at a time
module wresp_clear_arbiter (
    input  wire                            hclk,
    input  wire                            start_resetting_w,
    input  wire                            en,
    input  wire afi_wresp_pkg::chn_mask_t  reset_pointers,  // per-channel request pulses
    input  wire                            resp_pending,    // response waiting or updating
    output wire                            clear_busy,
    output afi_wresp_pkg::upd_state_t      clear_state,
    output afi_wresp_pkg::chn_t            clear_chn
);

    afi_wresp_pkg::chn_mask_t req_r;     // sticky requests, lowest channel served first
    afi_wresp_pkg::chn_mask_t done_mask; // request served by this cycle's eof write
    afi_wresp_pkg::chn_t      pick_chn;  // lowest requesting channel
    logic                     en_d;      // en delayed, for the rising edge
    logic                     clear_go;  // start a clear at the next edge

    always_comb begin
        pick_chn = '0;
        for (int i = `AFI_CHANNELS - 1; i >= 0; i--) begin
            if (req_r[i]) begin
                pick_chn = afi_wresp_pkg::chn_t'(i); // lower index overrides
            end
        end
    end

    assign clear_go   = en && (clear_state == afi_wresp_pkg::UPD_IDLE) && (|req_r) && !resp_pending;
    assign clear_busy = clear_go || (clear_state != afi_wresp_pkg::UPD_IDLE); // holds bready low
    assign done_mask  = (clear_state == afi_wresp_pkg::UPD_WR_EOF) ?
                        afi_wresp_pkg::chn_mask_t'(1) << clear_chn : '0;

    always_ff @(posedge hclk) begin
        if (start_resetting_w) begin
            en_d        <= 1'b0;
            req_r       <= '0;
            clear_state <= afi_wresp_pkg::UPD_IDLE;
        end else begin
            en_d <= en;
            if (en && !en_d) begin
                req_r <= '1;                                   // enable clears every channel
            end else begin
                req_r <= (req_r & ~done_mask) | reset_pointers;
            end
            if (!en) begin
                clear_state <= afi_wresp_pkg::UPD_IDLE;
            end else begin
                case (clear_state)
                    afi_wresp_pkg::UPD_IDLE: begin
                        if (clear_go) begin
                            clear_state <= afi_wresp_pkg::UPD_WR_CUR;
                        end
                    end
                    afi_wresp_pkg::UPD_WR_CUR: begin
                        clear_state <= afi_wresp_pkg::UPD_WR_EOF;   // second entry of the pair
                    end
                    default: begin
                        clear_state <= afi_wresp_pkg::UPD_IDLE;
                    end
                endcase
            end
        end
    end

    // channel latched at start, stable for both writes
    always_ff @(posedge hclk) begin
        if (clear_go) begin
            clear_chn <= pick_chn;
        end
    end

endmodule

`default_nettype wire

// ==== wresp/wresp_ptr_update.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afi_wresp_consts.svh"

// buffer length memory, chunk pointer memory and the pointer arithmetic
module wresp_ptr_update (
    input  wire                              hclk,
    input  wire afi_wresp_pkg::chunk_ptr_t   length_di,     // buffer length in chunks
    input  wire afi_wresp_pkg::chn_t         length_wa,
    input  wire                              length_we,
    input  wire afi_wresp_pkg::ptr_addr_t    chunk_ptr_ra,  // {eof, chn}
    output wire afi_wresp_pkg::chunk_ptr_t   chunk_ptr_rd,  // unregistered read
    input  wire afi_wresp_pkg::upd_state_t   upd_state,
    input  wire afi_wresp_pkg::chn_t         upd_chn,
    input  wire                              upd_eof_burst,
    input  wire afi_wresp_pkg::chunk_inc_t   upd_inc,
    input  wire afi_wresp_pkg::upd_state_t   clear_state,
    input  wire afi_wresp_pkg::chn_t         clear_chn
);

    afi_wresp_pkg::chunk_ptr_t len_mem [`AFI_CHANNELS];   // per-channel buffer length
    afi_wresp_pkg::chunk_ptr_t ptr_mem [`AFI_PTR_DEPTH];  // current 0..3, frame end 4..7

    afi_wresp_pkg::chunk_ptr_t sum_r;       // pointer advanced by the burst
    logic [`AFI_PTR_W:0]       diff_r;      // sum minus length, msb is the sign
    afi_wresp_pkg::chunk_ptr_t ptr_di;      // write-back data
    afi_wresp_pkg::ptr_addr_t  ptr_wa;      // write-back address
    afi_wresp_pkg::ptr_addr_t  cur_ra;      // current pointer of the updated channel
    afi_wresp_pkg::chn_t       wr_chn;
    logic                      clr_act;     // clear owns the write port
    logic                      wr_cur;
    logic                      wr_eof;
    logic                      ptr_we;

    assign chunk_ptr_rd = ptr_mem[chunk_ptr_ra];

    assign clr_act = (clear_state != afi_wresp_pkg::UPD_IDLE);
    // sequencers exclude each other, so the two sources just merge
    assign wr_cur  = (upd_state == afi_wresp_pkg::UPD_WR_CUR) ||
                     (clear_state == afi_wresp_pkg::UPD_WR_CUR);
    assign wr_eof  = ((upd_state == afi_wresp_pkg::UPD_WR_EOF) && upd_eof_burst) ||
                     (clear_state == afi_wresp_pkg::UPD_WR_EOF);
    assign ptr_we  = wr_cur || wr_eof;
    assign wr_chn  = clr_act ? clear_chn : upd_chn;
    assign ptr_wa  = {wr_eof, wr_chn};                  // eof entry in the upper half
    assign cur_ra  = {1'b0, upd_chn};

    // past the end of buffer - take the wrapped value
    assign ptr_di  = clr_act ? '0 :
                     (diff_r[`AFI_PTR_W] ? sum_r : diff_r[`AFI_PTR_W-1:0]);

    // software side length writes
    always_ff @(posedge hclk) begin
        if (length_we) begin
            len_mem[length_wa] <= length_di;
        end
    end

    // read, add, wrap
    always_ff @(posedge hclk) begin
        if (upd_state == afi_wresp_pkg::UPD_READ) begin
            sum_r <= ptr_mem[cur_ra] + afi_wresp_pkg::chunk_ptr_t'(upd_inc);
        end
        if (upd_state == afi_wresp_pkg::UPD_WRAP) begin
            diff_r <= {1'b0, sum_r} - {1'b0, len_mem[upd_chn]}; // negative - no wrap
        end
    end

    // single write port, current then eof entry holding the same value
    always_ff @(posedge hclk) begin
        if (ptr_we) begin
            ptr_mem[ptr_wa] <= ptr_di;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/afi_wresp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// write response pointer tracker for the four compressor channels on one AXI HP port
module afi_wresp_top (
    input  wire                              hclk,
    input  wire                              start_resetting_w,
    input  wire                              en,              // rising edge clears all pointers
    input  wire afi_wresp_pkg::chunk_ptr_t   length_di,
    input  wire afi_wresp_pkg::chn_t         length_wa,
    input  wire                              length_we,
    input  wire afi_wresp_pkg::chn_mask_t    reset_pointers,
    input  wire afi_wresp_pkg::ptr_addr_t    chunk_ptr_ra,
    output wire afi_wresp_pkg::chunk_ptr_t   chunk_ptr_rd,
    output wire afi_wresp_pkg::chn_mask_t    eof_written,
    input  wire                              afi_bvalid,
    output wire                              afi_bready,
    input  wire afi_wresp_pkg::resp_id_t     afi_bid
);

    wire afi_wresp_pkg::upd_state_t upd_state;     // response update step
    wire afi_wresp_pkg::chn_t       upd_chn;
    wire                            upd_eof_burst;
    wire afi_wresp_pkg::chunk_inc_t upd_inc;
    wire afi_wresp_pkg::upd_state_t clear_state;   // clear step, same encoding
    wire afi_wresp_pkg::chn_t       clear_chn;
    wire                            clear_busy;
    wire                            resp_pending;

    wresp_id_decode u_id_decode (
        .hclk              (hclk),
        .start_resetting_w (start_resetting_w),
        .en                (en),
        .afi_bvalid        (afi_bvalid),
        .afi_bid           (afi_bid),
        .clear_busy        (clear_busy),
        .afi_bready        (afi_bready),
        .eof_written       (eof_written),
        .resp_pending      (resp_pending),
        .upd_state         (upd_state),
        .upd_chn           (upd_chn),
        .upd_eof_burst     (upd_eof_burst),
        .upd_inc           (upd_inc)
    );

    wresp_clear_arbiter u_clear_arbiter (
        .hclk              (hclk),
        .start_resetting_w (start_resetting_w),
        .en                (en),
        .reset_pointers    (reset_pointers),
        .resp_pending      (resp_pending),
        .clear_busy        (clear_busy),
        .clear_state       (clear_state),
        .clear_chn         (clear_chn)
    );

    wresp_ptr_update u_ptr_update (
        .hclk              (hclk),
        .length_di         (length_di),
        .length_wa         (length_wa),
        .length_we         (length_we),
        .chunk_ptr_ra      (chunk_ptr_ra),
        .chunk_ptr_rd      (chunk_ptr_rd),
        .upd_state         (upd_state),
        .upd_chn           (upd_chn),
        .upd_eof_burst     (upd_eof_burst),
        .upd_inc           (upd_inc),
        .clear_state       (clear_state),
        .clear_chn         (clear_chn)
    );

endmodule

`default_nettype wire

// ==== test/tb_afi_wresp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "afi_wresp_consts.svh"

module tb_afi_wresp;

    localparam int CLK_PERIOD = 40;
    localparam int N_RESP     = 120;                           // checked one by one
    localparam int N_BURST    = 24;                            // back to back responses
    localparam int N_CLR      = 10;                            // reset_pointers rounds
    localparam int N_CLR_RESP = 3;                             // responses before each clear round
    localparam int N_DROP     = 16;                            // responses while en is low
    localparam int TOTAL_RESP = N_RESP + N_BURST + N_CLR * N_CLR_RESP + N_DROP;
    localparam int TOTAL_CLR  = (N_CLR + 2) * `AFI_CHANNELS;   // two en rises clear all channels
    localparam int N_CHECKS   = N_RESP + N_CLR + 6;
    localparam int CHECK_CYC  = `AFI_PTR_DEPTH + 3;            // readback plus idle wait
    localparam int CYC_LIMIT  = TOTAL_RESP * 8 + TOTAL_CLR * 4 + N_CHECKS * CHECK_CYC + 100;

    logic                      hclk;
    logic                      start_resetting_w;
    logic                      en;
    afi_wresp_pkg::chunk_ptr_t length_di;
    afi_wresp_pkg::chn_t       length_wa;
    logic                      length_we;
    afi_wresp_pkg::chn_mask_t  reset_pointers;
    afi_wresp_pkg::ptr_addr_t  chunk_ptr_ra;
    afi_wresp_pkg::chunk_ptr_t chunk_ptr_rd;
    afi_wresp_pkg::chn_mask_t  eof_written;
    logic                      afi_bvalid;
    logic                      afi_bready;
    afi_wresp_pkg::resp_id_t   afi_bid;

    afi_wresp_pkg::chunk_ptr_t len_model [`AFI_CHANNELS];    // buffer lengths as written
    afi_wresp_pkg::chunk_ptr_t ptr_model [`AFI_PTR_DEPTH];   // current 0..3, frame end 4..7
    afi_wresp_pkg::chn_mask_t  eof_exp_q1;                   // eof pulse expected one cycle out
    afi_wresp_pkg::chn_mask_t  eof_exp_q2;                   // eof pulse expected this cycle
    logic [31:0]               rng;
    int                        busy_left  = 0;               // update cycles with bready low
    int                        cycles     = 0;
    string                     test_name  = "reset";

    afi_wresp_top DUT (
        .hclk              (hclk),
        .start_resetting_w (start_resetting_w),
        .en                (en),
        .length_di         (length_di),
        .length_wa         (length_wa),
        .length_we         (length_we),
        .reset_pointers    (reset_pointers),
        .chunk_ptr_ra      (chunk_ptr_ra),
        .chunk_ptr_rd      (chunk_ptr_rd),
        .eof_written       (eof_written),
        .afi_bvalid        (afi_bvalid),
        .afi_bready        (afi_bready),
        .afi_bid           (afi_bid)
    );

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD / 2) hclk = ~hclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    // reference pointer rule for one accepted response
    task automatic apply_resp(input afi_wresp_pkg::resp_id_t id);
        afi_wresp_pkg::chn_t       chn;
        afi_wresp_pkg::chunk_ptr_t sum;
        chn = id[1:0];
        sum = ptr_model[chn] + afi_wresp_pkg::chunk_ptr_t'(id[4:3]);
        sum = sum + afi_wresp_pkg::chunk_ptr_t'(1);            // burst field is chunks minus one
        if (sum >= len_model[chn]) begin
            sum = sum - len_model[chn];                        // wrapped past buffer end
        end
        ptr_model[chn] = sum;
        if (id[2]) begin
            ptr_model[{1'b1, chn}] = sum;                      // frame end follows current
        end
    endtask

    // port monitor sampling a quarter period after the falling edge
    initial begin
        eof_exp_q1 = '0;
        eof_exp_q2 = '0;
        forever begin
            @(negedge hclk);
            #(CLK_PERIOD / 4);
            if (!start_resetting_w) begin
                assert (eof_written === eof_exp_q2) else
                    fail_run($sformatf("Error: %s eof_written expected %b actual %b",
                                       test_name, eof_exp_q2, eof_written));
            end
            if (busy_left > 0) begin
                assert (afi_bready === 1'b0) else
                    fail_run($sformatf("Error: %s afi_bready expected 0 actual %b",
                                       test_name, afi_bready));
                busy_left--;
            end
            eof_exp_q2 = eof_exp_q1;
            eof_exp_q1 = '0;
            if (afi_bvalid && afi_bready && !start_resetting_w) begin   // accepted at next edge
                if (en) begin
                    apply_resp(afi_bid);
                    busy_left = afi_bid[2] ? 4 : 3;            // read, wrap, write cur, write eof
                    if (afi_bid[2]) begin
                        eof_exp_q1 = afi_wresp_pkg::chn_mask_t'(1) << afi_bid[1:0];
                    end
                end
            end
        end
    end

    always @(posedge hclk) begin
        cycles++;
        if (cycles > CYC_LIMIT) begin
            fail_run($sformatf("Timeout in %s after %0d cycles, DUT stopped responding",
                               test_name, cycles));
        end
    end

    task automatic write_lengths();
        for (int c = 0; c < `AFI_CHANNELS; c++) begin
            rng = xorshift32(rng);
            length_wa = afi_wresp_pkg::chn_t'(c);
            length_di = afi_wresp_pkg::chunk_ptr_t'(32'd5 + rng % 32'd36); // 5..40 chunks
            length_we = 1'b1;
            len_model[c] = length_di;
            @(negedge hclk);
        end
        length_we = 1'b0;
    endtask

    // idle means bready high for 2 cycles with nothing offered
    task automatic wait_idle();
        int ready_cycles;
        ready_cycles = 0;
        while (ready_cycles < 2) begin
            @(negedge hclk);
            #(CLK_PERIOD / 4);
            if (afi_bready && !afi_bvalid) begin
                ready_cycles++;
            end else begin
                ready_cycles = 0;
            end
        end
        @(negedge hclk);
    endtask

    task automatic send_resp();
        rng = xorshift32(rng);
        afi_bvalid = 1'b1;
        afi_bid    = rng[5:0];                                 // chn, eof, burst, spare bit
        #(CLK_PERIOD / 4);
        while (!afi_bready) begin                              // hold bid while back-pressured
            @(negedge hclk);
            #(CLK_PERIOD / 4);
        end
        @(negedge hclk);
        afi_bvalid = 1'b0;
    endtask

    task automatic check_ptrs();
        for (int a = 0; a < `AFI_PTR_DEPTH; a++) begin
            chunk_ptr_ra = afi_wresp_pkg::ptr_addr_t'(a);
            #(CLK_PERIOD / 4);
            assert (chunk_ptr_rd === ptr_model[a]) else
                fail_run($sformatf("Error: %s chunk_ptr[%0d] expected %0d actual %0d",
                                   test_name, a, ptr_model[a], chunk_ptr_rd));
            @(negedge hclk);
        end
    endtask

    task automatic set_enable(input logic value);
        en = value;
        if (value) begin
            for (int a = 0; a < `AFI_PTR_DEPTH; a++) begin
                ptr_model[a] = '0;                             // rising en clears everything
            end
        end
        wait_idle();
    endtask

    task automatic pulse_clear(input afi_wresp_pkg::chn_mask_t mask);
        reset_pointers = mask;
        for (int c = 0; c < `AFI_CHANNELS; c++) begin
            if (mask[c]) begin
                ptr_model[c]     = '0;
                ptr_model[c + 4] = '0;
            end
        end
        @(negedge hclk);
        reset_pointers = '0;
    endtask

    initial begin
        afi_wresp_pkg::chn_mask_t mask;
        start_resetting_w = 1'b1;
        en                = 1'b0;
        length_di         = '0;
        length_wa         = '0;
        length_we         = 1'b0;
        reset_pointers    = '0;
        chunk_ptr_ra      = '0;
        afi_bvalid        = 1'b0;
        afi_bid           = '0;
        rng               = 32'd18901;
        repeat (3) @(negedge hclk);
        start_resetting_w = 1'b0;
        @(negedge hclk);
        test_name = "enable_clear";
        write_lengths();
        set_enable(1'b1);
        check_ptrs();
        test_name = "random_resp";
        for (int i = 0; i < N_RESP; i++) begin
            send_resp();
            wait_idle();
            check_ptrs();
        end
        test_name = "back_pressure";
        for (int i = 0; i < N_BURST; i++) begin
            send_resp();                                       // next one waits for bready
        end
        wait_idle();
        check_ptrs();
        test_name = "reset_pointers";
        for (int i = 0; i < N_CLR; i++) begin
            for (int k = 0; k < N_CLR_RESP; k++) begin
                send_resp();
            end
            wait_idle();
            rng  = xorshift32(rng);
            mask = afi_wresp_pkg::chn_mask_t'(1) << rng[5:4];
            if (i % 2 == 1) begin
                mask = ~mask;                                  // three channels at once
            end
            pulse_clear(mask);
            wait_idle();
            check_ptrs();
        end
        test_name = "enable_low";
        set_enable(1'b0);
        for (int i = 0; i < N_DROP; i++) begin
            send_resp();                                       // dropped with the model untouched
        end
        wait_idle();
        check_ptrs();
        test_name = "enable_rise";
        set_enable(1'b1);
        check_ptrs();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/afi_wresp_pkg.sv
wresp/wresp_id_decode.sv
wresp/wresp_clear_arbiter.sv
wresp/wresp_ptr_update.sv
hdl/afi_wresp_top.sv
test/tb_afi_wresp.sv

// ==== Makefile ====
# Verilator build and run for the AFI write response tracker

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_afi_wresp
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
